/* hdl/sbus_macros.svh */
//**************************************************************************
// Width and size constants for the serial memory subsystem.
// Include this header wherever a width, the target count or the frame
// start code is needed. The bus types built on these live in sbus_pkg.
//**************************************************************************
`ifndef SBUS_MACROS_SVH
`define SBUS_MACROS_SVH

// data word and RAM geometry per target
`define SBUS_DATA_W     32
`define SBUS_ADDR_DEPTH 256
`define SBUS_ADDR_W     8

// targets on the shared serial bus
`define SBUS_SLAVES     3
`define SBUS_ID_W       2

// frame is start | id | r/w | burst | address, sent msb first
`define SBUS_START      3'b111
`define SBUS_FRAME_W    (3 + `SBUS_ID_W + 2 + `SBUS_ADDR_W)

`endif

/* hdl/sbus_pkg.sv */
//**************************************************************************
// Shared types of the serial memory subsystem: width typedefs, the
// command and response structs between the APB block and the serial
// master, and the FSM state encodings. Import with sbus_pkg::*.
//**************************************************************************
`default_nettype none
`include "sbus_macros.svh"

package sbus_pkg;

    typedef logic [`SBUS_DATA_W-1:0] sbus_data_t;
    typedef logic [`SBUS_ADDR_W-1:0] sbus_addr_t;
    typedef logic [`SBUS_ID_W-1:0]   sbus_id_t;

    // one transfer request, valid together with start
    typedef struct packed {
        logic       write;
        sbus_id_t   id;
        sbus_addr_t addr;
        sbus_data_t wdata;
    } sbus_cmd_t;

    // done pulses once per transfer
    typedef struct packed {
        logic       done;
        sbus_data_t rdata;
    } sbus_rsp_t;

    typedef enum logic [2:0] {
        M_IDLE, M_FRAME, M_WDATA, M_RWAIT, M_RDATA
    } master_state_t;

    typedef enum logic [2:0] {
        S_IDLE, S_FRAME, S_MATCH, S_WRITE, S_READ
    } slave_state_t;

endpackage

`default_nettype wire

/* hdl/sbus_apb_regs.sv */
//**************************************************************************
// APB register block of the serial memory subsystem.
// Holds the target address, slave id and write data, launches a serial
// transfer on a CMD write, answers STATUS and keeps the last read word.
// Zero wait states; pslverr flags unmapped offsets and refused commands.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "sbus_macros.svh"

module sbus_apb_regs import sbus_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [4:0] paddr,
    input  sbus_data_t pwdata,
    output sbus_data_t prdata,
    output logic       pready,
    output logic       pslverr,
    output sbus_cmd_t  cmd,
    output logic       start,
    input  logic       busy,
    input  sbus_rsp_t  rsp
);
    localparam logic [4:0] REG_ADDR   = 5'h00;
    localparam logic [4:0] REG_WDATA  = 5'h04;
    localparam logic [4:0] REG_CMD    = 5'h08;
    localparam logic [4:0] REG_STATUS = 5'h0C;
    localparam logic [4:0] REG_RDATA  = 5'h10;

    localparam sbus_data_t CMD_WRITE = 32'd1;
    localparam sbus_data_t CMD_READ  = 32'd2;

    sbus_addr_t addr_q;
    sbus_id_t   id_q;
    sbus_data_t wdata_q;
    sbus_data_t rdata_q;

    logic wr_access;
    logic mapped;
    logic cmd_wr;
    logic cmd_err;

    assign wr_access = psel & penable & pwrite;
    assign mapped    = (paddr == REG_ADDR) | (paddr == REG_WDATA) | (paddr == REG_CMD) |
                       (paddr == REG_STATUS) | (paddr == REG_RDATA);
    assign cmd_wr    = wr_access & (paddr == REG_CMD);
    assign cmd_err   = cmd_wr & (busy | (int'(id_q) >= `SBUS_SLAVES));

    assign pready  = 1'b1;
    assign pslverr = psel & penable & (~mapped | cmd_err);

    // launch in the access cycle, other CMD values do nothing
    assign start     = cmd_wr & ~cmd_err & ((pwdata == CMD_WRITE) | (pwdata == CMD_READ));
    assign cmd.write = (pwdata == CMD_WRITE);
    assign cmd.id    = id_q;
    assign cmd.addr  = addr_q;
    assign cmd.wdata = wdata_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            addr_q  <= '0;
            id_q    <= '0;
            wdata_q <= '0;
            rdata_q <= '0;
        end else begin
            if (wr_access && paddr == REG_ADDR) begin
                addr_q <= pwdata[`SBUS_ADDR_W-1:0];
                id_q   <= pwdata[`SBUS_ADDR_W +: `SBUS_ID_W];
            end
            if (wr_access && paddr == REG_WDATA) begin
                wdata_q <= pwdata;
            end
            // master holds its last read word, so a write done keeps RDATA
            if (rsp.done) begin
                rdata_q <= rsp.rdata;
            end
        end
    end

    always_comb begin
        case (paddr)
            REG_ADDR:   prdata = sbus_data_t'({id_q, addr_q});
            REG_WDATA:  prdata = wdata_q;
            REG_STATUS: prdata = sbus_data_t'(busy);
            REG_RDATA:  prdata = rdata_q;
            default:    prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/sbus_master.sv */
//**************************************************************************
// Serial bus master. Takes one command per start pulse, sends the frame
// msb first on control, waits for the addressed target to drop ready,
// then sends 32 write bits on wd or collects 32 read bits from rd.
// busy covers the whole transfer up to and including the done pulse.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "sbus_macros.svh"

module sbus_master import sbus_pkg::*; (
    input  logic                    clk,
    input  logic                    resetn,
    input  sbus_cmd_t               cmd,
    input  logic                    start,
    output logic                    busy,
    output sbus_rsp_t               rsp,
    output logic                    control,
    output logic                    wd,
    output logic                    valid,
    output logic                    last,
    input  logic [`SBUS_SLAVES-1:0] rd,
    input  logic [`SBUS_SLAVES-1:0] ready
);
    localparam int CNT_W = $clog2(`SBUS_DATA_W);
    localparam int FW    = `SBUS_FRAME_W;

    master_state_t  state;
    logic [CNT_W-1:0] bit_cnt;
    logic [FW-1:0]  frame_sr;
    sbus_data_t     data_sr;
    sbus_id_t       id_q;
    logic           write_q;
    logic           rd_bit;

    // only the addressed target's read line counts
    assign rd_bit = rd[id_q];

    assign control = (state == M_FRAME) & frame_sr[FW-1];
    assign valid   = (state == M_WDATA);
    assign wd      = valid & data_sr[`SBUS_DATA_W-1];
    assign last    = valid & (bit_cnt == CNT_W'(`SBUS_DATA_W - 1));
    assign busy    = (state != M_IDLE) | rsp.done;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= M_IDLE;
            bit_cnt <= '0;
            rsp     <= '0;
        end else begin
            rsp.done <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (start) begin
                        bit_cnt <= '0;
                        state   <= M_FRAME;
                    end
                end
                M_FRAME: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(FW - 1)) begin
                        state <= M_RWAIT;
                    end
                end
                // target is in its match cycle
                M_RWAIT: begin
                    if (!ready[id_q]) begin
                        bit_cnt <= '0;
                        state   <= write_q ? M_WDATA : M_RDATA;
                    end
                end
                M_WDATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (last) begin
                        rsp.done <= 1'b1;
                        state    <= M_IDLE;
                    end
                end
                M_RDATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(`SBUS_DATA_W - 1)) begin
                        rsp.done  <= 1'b1;
                        rsp.rdata <= {data_sr[`SBUS_DATA_W-2:0], rd_bit};
                        state     <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // frame and data shifters
    always_ff @(posedge clk) begin
        if (state == M_IDLE && start) begin
            frame_sr <= {`SBUS_START, cmd.id, cmd.write, 1'b0, cmd.addr};
            data_sr  <= cmd.wdata;
            id_q     <= cmd.id;
            write_q  <= cmd.write;
        end else if (state == M_FRAME) begin
            frame_sr <= frame_sr << 1;
        end else if (state == M_WDATA) begin
            data_sr <= data_sr << 1;
        end else if (state == M_RDATA) begin
            data_sr <= {data_sr[`SBUS_DATA_W-2:0], rd_bit};
        end
    end

endmodule

`default_nettype wire

/* hdl/sbus_ram_slave.sv */
//**************************************************************************
// Serial RAM target. Shifts in the frame from control, spends one match
// cycle with ready low, then either collects a write word from wd while
// valid is high or shifts a stored word out on rd, msb first.
// Instantiate once per target with a distinct SLAVE_ID.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "sbus_macros.svh"

module sbus_ram_slave import sbus_pkg::*; #(
    parameter sbus_id_t SLAVE_ID = 2'd0
) (
    input  logic clk,
    input  logic resetn,
    input  logic control,
    input  logic wd,
    input  logic valid,
    input  logic last,
    output logic rd,
    output logic ready
);
    localparam int CNT_W   = $clog2(`SBUS_DATA_W);
    localparam int FW      = `SBUS_FRAME_W;
    localparam int START_W = 3;

    slave_state_t     state;
    logic [CNT_W-1:0] bit_cnt;
    logic [FW-1:0]    frame_sr;
    sbus_data_t       wbuf;
    sbus_data_t       rbuf;
    sbus_addr_t       addr_q;
    sbus_data_t       ram [`SBUS_ADDR_DEPTH];

    logic [START_W-1:0] f_start;
    sbus_id_t           f_id;
    logic               f_write;
    logic               f_burst;
    sbus_addr_t         f_addr;
    logic               hit;
    sbus_data_t         wword;

    // frame fields once all bits are in
    assign f_start = frame_sr[FW-1 -: START_W];
    assign f_id    = frame_sr[FW-START_W-1 -: `SBUS_ID_W];
    assign f_write = frame_sr[`SBUS_ADDR_W+1];
    assign f_burst = frame_sr[`SBUS_ADDR_W];
    assign f_addr  = frame_sr[`SBUS_ADDR_W-1:0];

    // bursts are not served, such a frame is ignored
    assign hit   = (f_start == `SBUS_START) & (f_id == SLAVE_ID) & ~f_burst;
    assign wword = {wbuf[`SBUS_DATA_W-2:0], wd};

    assign ready = (state == S_IDLE) | (state == S_FRAME);
    assign rd    = (state == S_READ) & rbuf[`SBUS_DATA_W-1];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= S_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                // first start bit opens the frame
                S_IDLE: begin
                    if (control) begin
                        bit_cnt <= CNT_W'(1);
                        state   <= S_FRAME;
                    end
                end
                S_FRAME: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(FW - 1)) begin
                        state <= S_MATCH;
                    end
                end
                S_MATCH: begin
                    bit_cnt <= '0;
                    if (!hit) begin
                        state <= S_IDLE;
                    end else if (f_write) begin
                        state <= S_WRITE;
                    end else begin
                        state <= S_READ;
                    end
                end
                S_WRITE: begin
                    if (valid && last) begin
                        state <= S_IDLE;
                    end
                end
                S_READ: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(`SBUS_DATA_W - 1)) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // shifters and RAM array
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE, S_FRAME: begin
                frame_sr <= {frame_sr[FW-2:0], control};
            end
            S_MATCH: begin
                addr_q <= f_addr;
                rbuf   <= ram[f_addr];
            end
            S_WRITE: begin
                if (valid) begin
                    wbuf <= wword;
                    if (last) begin
                        ram[addr_q] <= wword;
                    end
                end
            end
            S_READ: begin
                rbuf <= rbuf << 1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/sbus_top.sv */
//**************************************************************************
// Top level of the serial memory subsystem. APB host port on the
// outside; inside, the register block feeds the serial master, which
// drives one shared serial bus to three RAM targets with ids 0 to 2.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "sbus_macros.svh"

module sbus_top import sbus_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [4:0] paddr,
    input  sbus_data_t pwdata,
    output sbus_data_t prdata,
    output logic       pready,
    output logic       pslverr
);
    sbus_cmd_t cmd;
    sbus_rsp_t rsp;
    logic      start;
    logic      busy;

    // shared serial lines, one rd and ready bit per target
    logic                    control;
    logic                    wd;
    logic                    valid;
    logic                    last;
    logic [`SBUS_SLAVES-1:0] rd;
    logic [`SBUS_SLAVES-1:0] ready;

    sbus_apb_regs sbus_apb_regs_i (
        .clk     (clk),
        .resetn  (resetn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cmd     (cmd),
        .start   (start),
        .busy    (busy),
        .rsp     (rsp)
    );

    sbus_master sbus_master_i (
        .clk     (clk),
        .resetn  (resetn),
        .cmd     (cmd),
        .start   (start),
        .busy    (busy),
        .rsp     (rsp),
        .control (control),
        .wd      (wd),
        .valid   (valid),
        .last    (last),
        .rd      (rd),
        .ready   (ready)
    );

    for (genvar i = 0; i < `SBUS_SLAVES; i++) begin : g_slave
        sbus_ram_slave #(
            .SLAVE_ID (sbus_id_t'(i))
        ) sbus_ram_slave_i (
            .clk     (clk),
            .resetn  (resetn),
            .control (control),
            .wd      (wd),
            .valid   (valid),
            .last    (last),
            .rd      (rd[i]),
            .ready   (ready[i])
        );
    end

endmodule

`default_nettype wire

/* dv/sbus_checker.sv */
//**************************************************************************
// Protocol assertions for the serial memory subsystem, bound into
// sbus_top. Covers the APB response rules and the idle state of the
// serial targets. Failures are counted in fail_count.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "sbus_macros.svh"

module sbus_checker (
    input logic                    clk,
    input logic                    resetn,
    input logic                    psel,
    input logic                    penable,
    input logic                    pready,
    input logic                    pslverr,
    input logic                    busy,
    input logic [`SBUS_SLAVES-1:0] ready
);
    int fail_count = 0;

    // zero wait states
    pready_high: assert property (@(posedge clk) disable iff (!resetn) pready)
        else begin
            fail_count++;
            $error("pready low outside reset");
        end

    pslverr_in_access: assert property (
        @(posedge clk) disable iff (!resetn) pslverr |-> (psel && penable))
        else begin
            fail_count++;
            $error("pslverr raised outside an access phase");
        end

    // no target left mid transfer once the master is idle
    ready_when_idle: assert property (@(posedge clk) disable iff (!resetn) !busy |-> &ready)
        else begin
            fail_count++;
            $error("target ready low while master idle");
        end

endmodule

bind sbus_top sbus_checker sbus_checker_i (
    .clk     (clk),
    .resetn  (resetn),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .busy    (busy),
    .ready   (ready)
);

`default_nettype wire

/* dv/sbus_tb.sv */
//**************************************************************************
// Testbench for the serial memory subsystem. Drives the APB port of
// sbus_top, mirrors every write in a reference memory per target and
// compares read data, error responses and status against it.
// Run from the project root with files.f; protocol rules come from the
// bound sbus_checker.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "sbus_macros.svh"

module sbus_tb import sbus_pkg::*; ();
    localparam logic [4:0] OFS_ADDR   = 5'h00;
    localparam logic [4:0] OFS_WDATA  = 5'h04;
    localparam logic [4:0] OFS_CMD    = 5'h08;
    localparam logic [4:0] OFS_STATUS = 5'h0C;
    localparam logic [4:0] OFS_RDATA  = 5'h10;
    localparam sbus_data_t CMD_WRITE  = 32'd1;
    localparam sbus_data_t CMD_READ   = 32'd2;

    localparam int CLK_NS       = 40;
    localparam int RESET_CYCLES = 10;
    localparam int N_RANDOM     = 40;
    // directed transfers and illegal accesses, rounded up
    localparam int N_XFERS      = N_RANDOM + 30;
    localparam int TIMEOUT_NS   = (N_XFERS * 60 + RESET_CYCLES) * CLK_NS;

    logic       clk;
    logic       resetn;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [4:0] paddr;
    sbus_data_t pwdata;
    sbus_data_t prdata;
    logic       pready;
    logic       pslverr;

    int errors = 0;
    int checks = 0;

    sbus_data_t ref_mem [`SBUS_SLAVES][`SBUS_ADDR_DEPTH];
    logic [`SBUS_ID_W+`SBUS_ADDR_W-1:0] written [$];

    sbus_top sbus_top_i (
        .clk     (clk),
        .resetn  (resetn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic check_value(input string name, input sbus_data_t expected,
                               input sbus_data_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one zero wait state transfer, sampled mid access phase
    task automatic apb_access(input logic write, input logic [4:0] ofs,
                              input sbus_data_t wdata, output sbus_data_t rdata,
                              output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= ofs;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_idle();
        sbus_data_t status;
        logic       err;
        status = 32'h1;
        while (status[0] !== 1'b0) begin
            apb_access(1'b0, OFS_STATUS, '0, status, err);
        end
    endtask

    // load ADDR and WDATA, then issue the command
    task automatic start_cmd(input sbus_id_t id, input sbus_addr_t addr, input sbus_data_t data,
                             input logic write, input logic exp_err);
        sbus_data_t unused;
        logic       err;
        apb_access(1'b1, OFS_ADDR, sbus_data_t'({id, addr}), unused, err);
        apb_access(1'b1, OFS_WDATA, data, unused, err);
        apb_access(1'b1, OFS_CMD, write ? CMD_WRITE : CMD_READ, unused, err);
        check_value("pslverr", sbus_data_t'(exp_err), sbus_data_t'(err));
    endtask

    task automatic write_word(input sbus_id_t id, input sbus_addr_t addr, input sbus_data_t data);
        start_cmd(id, addr, data, 1'b1, 1'b0);
        wait_idle();
        ref_mem[id][addr] = data;
        written.push_back({id, addr});
    endtask

    task automatic read_word(input sbus_id_t id, input sbus_addr_t addr);
        sbus_data_t rdata;
        logic       err;
        start_cmd(id, addr, '0, 1'b0, 1'b0);
        wait_idle();
        apb_access(1'b0, OFS_RDATA, '0, rdata, err);
        check_value("rdata", ref_mem[id][addr], rdata);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: transfers did not finish within %0d ns", TIMEOUT_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin
        sbus_data_t                         rdata;
        logic                               err;
        logic [`SBUS_ID_W+`SBUS_ADDR_W-1:0] key;
        int                                 total;
        void'($urandom(32'hcdaf22fd));
        clk     = 1'b0;
        resetn  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;

        // reset state
        apb_access(1'b0, OFS_STATUS, '0, rdata, err);
        check_value("status", '0, rdata);
        check_value("pslverr", '0, sbus_data_t'(err));
        apb_access(1'b0, OFS_RDATA, '0, rdata, err);
        check_value("rdata", '0, rdata);
        check_value("pslverr", '0, sbus_data_t'(err));

        write_word(2'd0, 8'h3C, 32'hA5C3_0F12);
        read_word(2'd0, 8'h3C);

        // same address in every target
        write_word(2'd0, 8'h5A, 32'h1111_0000);
        write_word(2'd1, 8'h5A, 32'h2222_1111);
        write_word(2'd2, 8'h5A, 32'h3333_2222);
        for (int i = 0; i < `SBUS_SLAVES; i++) begin
            read_word(sbus_id_t'(i), 8'h5A);
        end

        // second command lands while the first is in flight
        write_word(2'd2, 8'h21, 32'hC0DE_0021);
        start_cmd(2'd1, 8'h20, 32'hBEEF_0020, 1'b1, 1'b0);
        start_cmd(2'd2, 8'h21, 32'hDEAD_0000, 1'b1, 1'b1);
        wait_idle();
        ref_mem[1][8'h20] = 32'hBEEF_0020;
        written.push_back({2'd1, 8'h20});
        read_word(2'd1, 8'h20);
        read_word(2'd2, 8'h21);

        // slave id 3 and unmapped offsets
        start_cmd(2'd3, 8'h10, '0, 1'b0, 1'b1);
        apb_access(1'b1, 5'h14, 32'h1234_5678, rdata, err);
        check_value("pslverr", 32'h1, sbus_data_t'(err));
        apb_access(1'b0, 5'h1C, '0, rdata, err);
        check_value("pslverr", 32'h1, sbus_data_t'(err));
        apb_access(1'b0, OFS_STATUS, '0, rdata, err);
        check_value("status", '0, rdata);

        for (int n = 0; n < N_RANDOM; n++) begin
            if (written.size() == 0 || $urandom_range(1, 0) == 1) begin
                write_word(sbus_id_t'($urandom_range(`SBUS_SLAVES - 1, 0)),
                           sbus_addr_t'($urandom), $urandom);
            end else begin
                key = written[$urandom_range(written.size() - 1, 0)];
                read_word(key[`SBUS_ADDR_W +: `SBUS_ID_W], key[`SBUS_ADDR_W-1:0]);
            end
        end

        total = errors + sbus_top_i.sbus_checker_i.fail_count;
        $display("checks: %0d, value errors: %0d, assertion errors: %0d",
                 checks, errors, sbus_top_i.sbus_checker_i.fail_count);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+hdl
hdl/sbus_pkg.sv
hdl/sbus_apb_regs.sv
hdl/sbus_master.sv
hdl/sbus_ram_slave.sv
hdl/sbus_top.sv
dv/sbus_checker.sv
dv/sbus_tb.sv

/* Bender.yml */
package:
  name: sbus

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/sbus_pkg.sv
      - hdl/sbus_apb_regs.sv
      - hdl/sbus_master.sv
      - hdl/sbus_ram_slave.sv
      - hdl/sbus_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/sbus_checker.sv
      - dv/sbus_tb.sv
